/* hw/core_defs.svh */
// core width, register index, ALU code width and reset address macros
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define XLEN 64

// instruction word width
`define ILEN 32

// register index width, 32 integer registers
`define REG_ADDR_W 5

// ALU operation code width
`define ALU_OP_W 4

// first fetch address
`define RESET_PC 64'h8000_0000

`endif

/* hw/isa_pkg.sv */
// instruction word union plus opcode and funct constants of the RV64I subset
`include "core_defs.svh"

package isa_pkg;

  // one instruction word, read as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } r_view;
    struct packed {
      logic [11:0]            imm12;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } i_view;
  } inst_word_u;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // custom serial output and stop
  localparam logic [6:0] OPC_PUTCH  = 7'h7b;
  localparam logic [6:0] OPC_HALT   = 7'h6b;

  // funct3, shared by register and immediate forms
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  // selects sub over add in the register form
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

endpackage

/* hw/alu_pkg.sv */
// ALU operation codes and the ALU compute function
`include "core_defs.svh"

package alu_pkg;

  localparam logic [`ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [`ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [`ALU_OP_W-1:0] ALU_AND    = 4'd2;
  localparam logic [`ALU_OP_W-1:0] ALU_OR     = 4'd3;
  localparam logic [`ALU_OP_W-1:0] ALU_XOR    = 4'd4;
  localparam logic [`ALU_OP_W-1:0] ALU_SLT    = 4'd5;
  localparam logic [`ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
  // operand a straight through, for putch and halt
  localparam logic [`ALU_OP_W-1:0] ALU_PASS_A = 4'd7;

  function automatic logic [`XLEN-1:0] alu_compute(
    input logic [`ALU_OP_W-1:0] op,
    input logic [`XLEN-1:0]     a,
    input logic [`XLEN-1:0]     b
  );
    logic [`XLEN-1:0] res;
    res = '0;
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLT:  res[0] = $signed(a) < $signed(b);
      ALU_SLTU: res[0] = a < b;
      default:  res = a;
    endcase
    return res;
  endfunction

endpackage

/* hw/core_ifs.sv */
// id_ex_if, ex_wb_if and reg_read_if stage interfaces
`include "core_defs.svh"

// decode to execute
interface id_ex_if;
  logic                   valid;
  logic [`XLEN-1:0]       pc;
  logic [`ALU_OP_W-1:0]   alu_op;
  logic [`XLEN-1:0]       op_a;
  logic [`XLEN-1:0]       op_b;
  logic                   wen;
  logic [`REG_ADDR_W-1:0] wdest;
  logic                   is_putch;
  logic                   is_halt;

  modport source (output valid, pc, alu_op, op_a, op_b, wen, wdest, is_putch, is_halt);
  modport sink   (input  valid, pc, alu_op, op_a, op_b, wen, wdest, is_putch, is_halt);
endinterface

// execute to writeback
interface ex_wb_if;
  logic                   valid;
  logic [`XLEN-1:0]       pc;
  logic                   wen;
  logic [`REG_ADDR_W-1:0] wdest;
  logic [`XLEN-1:0]       result;
  logic                   is_putch;
  logic                   is_halt;

  modport source (output valid, pc, wen, wdest, result, is_putch, is_halt);
  modport sink   (input  valid, pc, wen, wdest, result, is_putch, is_halt);
endinterface

// two combinational read ports of the register file
interface reg_read_if;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  modport requester (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
  modport responder (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

/* hw/fetch_unit.sv */
// fetch stage with PC, fetch handshake and the fetch-to-decode register
`include "core_defs.svh"

module fetch_unit (
  input  logic              clock,
  input  logic              reset,
  output logic              fetch_valid,
  output logic [`XLEN-1:0]  fetch_addr,
  input  logic              fetch_ready,
  input  logic [`ILEN-1:0]  fetch_data,
  input  logic              fetch_stop,
  output logic              if_valid,
  output logic [`XLEN-1:0]  if_pc,
  output logic [`ILEN-1:0]  if_inst
);

  logic             fetch_en;
  logic [`XLEN-1:0] pc;
  logic             accept;

  // requests start one cycle out of reset
  assign fetch_valid = fetch_en & ~fetch_stop;
  assign fetch_addr  = pc;
  assign accept      = fetch_valid & fetch_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_en <= 1'b0;
      pc       <= `RESET_PC;
      if_valid <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
      if_valid <= accept;
      // no branches, so the next address is always pc + 4
      if (accept) begin
        pc <= pc + `XLEN'd4;
      end
    end
  end

  // fetched word and its address
  always_ff @(posedge clock) begin
    if (accept) begin
      if_pc   <= pc;
      if_inst <= fetch_data;
    end
  end

  // memory may stall, address must not move meanwhile
  a_addr_stable: assert property (
    @(posedge clock) disable iff (reset)
    fetch_valid && !fetch_ready |=> $stable(fetch_addr)
  );

endmodule

/* hw/decode_unit.sv */
// decode stage with operand read, EX forwarding and halt stop
`include "core_defs.svh"

module decode_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   if_valid,
  input  logic [`XLEN-1:0]       if_pc,
  input  logic [`ILEN-1:0]       if_inst,
  reg_read_if.requester          rd,
  input  logic                   fwd_valid,
  input  logic [`REG_ADDR_W-1:0] fwd_dest,
  input  logic [`XLEN-1:0]       fwd_data,
  id_ex_if.source                id_ex,
  output logic                   fetch_stop
);

  import isa_pkg::*;
  import alu_pkg::*;

  inst_word_u             inst;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`XLEN-1:0]       src1;
  logic [`XLEN-1:0]       src2;
  logic [`XLEN-1:0]       imm;
  logic [`ALU_OP_W-1:0]   dec_op;
  logic                   dec_wen;
  logic                   use_imm;
  logic                   dec_putch;
  logic                   dec_halt;
  logic                   accept;

  // funct3 to ALU op with a supported flag in the msb
  function automatic logic [`ALU_OP_W:0] funct3_op(input logic [2:0] f3, input logic sub);
    case (f3)
      FUNCT3_ADD:  return {1'b1, sub ? ALU_SUB : ALU_ADD};
      FUNCT3_SLT:  return {1'b1, ALU_SLT};
      FUNCT3_SLTU: return {1'b1, ALU_SLTU};
      FUNCT3_XOR:  return {1'b1, ALU_XOR};
      FUNCT3_OR:   return {1'b1, ALU_OR};
      FUNCT3_AND:  return {1'b1, ALU_AND};
      default:     return {1'b0, ALU_PASS_A};
    endcase
  endfunction

  assign inst = if_inst;
  assign rs1  = inst.r_view.rs1;
  assign rs2  = inst.r_view.rs2;
  assign imm  = {{(`XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};

  assign rd.rs1_addr = rs1;
  assign rd.rs2_addr = rs2;

  // result still in EX wins over the register file
  assign src1 = (fwd_valid && fwd_dest == rs1 && rs1 != '0) ? fwd_data : rd.rs1_data;
  assign src2 = (fwd_valid && fwd_dest == rs2 && rs2 != '0) ? fwd_data : rd.rs2_data;

  always_comb begin
    dec_op    = ALU_PASS_A;
    dec_wen   = 1'b0;
    use_imm   = 1'b0;
    dec_putch = 1'b0;
    dec_halt  = 1'b0;
    case (inst.r_view.opcode)
      OPC_OP:
        {dec_wen, dec_op} = funct3_op(inst.r_view.funct3, inst.r_view.funct7 == FUNCT7_SUB);
      OPC_OP_IMM: begin
        {dec_wen, dec_op} = funct3_op(inst.i_view.funct3, 1'b0);
        use_imm = 1'b1;
      end
      OPC_PUTCH: dec_putch = 1'b1;
      OPC_HALT:  dec_halt  = 1'b1;
      // anything else retires as a no-op
      default: ;
    endcase
  end

  // nothing after a halt gets through
  assign accept = if_valid & ~fetch_stop;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
      fetch_stop  <= 1'b0;
    end else begin
      id_ex.valid <= accept;
      if (accept && dec_halt) begin
        fetch_stop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      id_ex.pc       <= if_pc;
      id_ex.alu_op   <= dec_op;
      id_ex.op_a     <= src1;
      id_ex.op_b     <= use_imm ? imm : src2;
      id_ex.wen      <= dec_wen;
      id_ex.wdest    <= inst.r_view.rd;
      id_ex.is_putch <= dec_putch;
      id_ex.is_halt  <= dec_halt;
    end
  end

  // halt is the last instruction handed to EX
  a_no_issue_after_halt: assert property (
    @(posedge clock) disable iff (reset)
    id_ex.valid && id_ex.is_halt |=> !id_ex.valid
  );

endmodule

/* hw/reg_file.sv */
// 32 by 64-bit integer register file with write-through bypass
`include "core_defs.svh"

module reg_file (
  input  logic                   clock,
  input  logic                   reset,
  reg_read_if.responder          rd,
  input  logic                   wr_ena,
  input  logic [`REG_ADDR_W-1:0] wr_addr,
  input  logic [`XLEN-1:0]       wr_data
);

  logic [`XLEN-1:0] regs [0:(1<<`REG_ADDR_W)-1];

  // x0 reads zero and a same-cycle write is seen at once
  assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 :
                       (wr_ena && wr_addr == rd.rs1_addr) ? wr_data : regs[rd.rs1_addr];
  assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 :
                       (wr_ena && wr_addr == rd.rs2_addr) ? wr_data : regs[rd.rs2_addr];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  a_wr_addr_known: assert property (
    @(posedge clock) disable iff (reset)
    wr_ena |-> !$isunknown(wr_addr)
  );

endmodule

/* hw/execute_unit.sv */
// execute stage with ALU, forwarding source and the execute-to-writeback register
`include "core_defs.svh"

module execute_unit (
  input  logic                   clock,
  input  logic                   reset,
  id_ex_if.sink                  id_ex,
  ex_wb_if.source                ex_wb,
  output logic                   fwd_valid,
  output logic [`REG_ADDR_W-1:0] fwd_dest,
  output logic [`XLEN-1:0]       fwd_data
);

  import alu_pkg::*;

  logic [`XLEN-1:0] result;

  assign result = alu_compute(id_ex.alu_op, id_ex.op_a, id_ex.op_b);

  // unregistered result goes back to decode
  assign fwd_valid = id_ex.valid & id_ex.wen;
  assign fwd_dest  = id_ex.wdest;
  assign fwd_data  = result;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_wb.valid <= 1'b0;
    end else begin
      ex_wb.valid <= id_ex.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id_ex.valid) begin
      ex_wb.pc       <= id_ex.pc;
      ex_wb.wen      <= id_ex.wen;
      ex_wb.wdest    <= id_ex.wdest;
      ex_wb.result   <= result;
      ex_wb.is_putch <= id_ex.is_putch;
      ex_wb.is_halt  <= id_ex.is_halt;
    end
  end

endmodule

/* hw/writeback_unit.sv */
// writeback stage with register write, commit trace, serial output and halt state
`include "core_defs.svh"

module writeback_unit (
  input  logic                   clock,
  input  logic                   reset,
  ex_wb_if.sink                  ex_wb,
  output logic                   wr_ena,
  output logic [`REG_ADDR_W-1:0] wr_addr,
  output logic [`XLEN-1:0]       wr_data,
  output logic                   commit_valid,
  output logic [`XLEN-1:0]       commit_pc,
  output logic                   commit_wen,
  output logic [`REG_ADDR_W-1:0] commit_wdest,
  output logic [`XLEN-1:0]       commit_wdata,
  output logic                   uart_valid,
  output logic [7:0]             uart_char,
  output logic                   halted,
  output logic [7:0]             halt_code
);

  assign wr_ena  = ex_wb.valid & ex_wb.wen;
  assign wr_addr = ex_wb.wdest;
  assign wr_data = ex_wb.result;

  // retirement trace, x0 writes still show their destination
  assign commit_valid = ex_wb.valid;
  assign commit_pc    = ex_wb.pc;
  assign commit_wen   = wr_ena;
  assign commit_wdest = ex_wb.wdest;
  assign commit_wdata = ex_wb.result;

  // putch passes rs1 through the ALU
  assign uart_valid = ex_wb.valid & ex_wb.is_putch;
  assign uart_char  = ex_wb.result[7:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (ex_wb.valid && ex_wb.is_halt) begin
      halted <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_wb.valid && ex_wb.is_halt) begin
      halt_code <= ex_wb.result[7:0];
    end
  end

  a_no_commit_halted: assert property (
    @(posedge clock) disable iff (reset)
    halted |-> !commit_valid
  );

endmodule

/* hw/core_top.sv */
// top level of the pipelined core, stage instances and wiring
`include "core_defs.svh"

module core_top (
  input  logic                   clock,
  input  logic                   reset,
  output logic                   fetch_valid,
  output logic [`XLEN-1:0]       fetch_addr,
  input  logic                   fetch_ready,
  input  logic [`ILEN-1:0]       fetch_data,
  output logic                   commit_valid,
  output logic [`XLEN-1:0]       commit_pc,
  output logic                   commit_wen,
  output logic [`REG_ADDR_W-1:0] commit_wdest,
  output logic [`XLEN-1:0]       commit_wdata,
  output logic                   uart_valid,
  output logic [7:0]             uart_char,
  output logic                   halted,
  output logic [7:0]             halt_code
);

  // fetch to decode
  logic                   if_valid;
  logic [`XLEN-1:0]       if_pc;
  logic [`ILEN-1:0]       if_inst;
  logic                   fetch_stop;

  // EX forwarding
  logic                   fwd_valid;
  logic [`REG_ADDR_W-1:0] fwd_dest;
  logic [`XLEN-1:0]       fwd_data;

  // register write port
  logic                   wr_ena;
  logic [`REG_ADDR_W-1:0] wr_addr;
  logic [`XLEN-1:0]       wr_data;

  id_ex_if    id_ex ();
  ex_wb_if    ex_wb ();
  reg_read_if rd_bus ();

  fetch_unit fetch_i (
    .clock, .reset,
    .fetch_valid, .fetch_addr, .fetch_ready, .fetch_data, .fetch_stop,
    .if_valid, .if_pc, .if_inst
  );

  decode_unit decode_i (
    .clock, .reset,
    .if_valid, .if_pc, .if_inst,
    .rd (rd_bus),
    .fwd_valid, .fwd_dest, .fwd_data,
    .id_ex (id_ex),
    .fetch_stop
  );

  reg_file reg_file_i (
    .clock, .reset,
    .rd (rd_bus),
    .wr_ena, .wr_addr, .wr_data
  );

  execute_unit execute_i (
    .clock, .reset,
    .id_ex (id_ex),
    .ex_wb (ex_wb),
    .fwd_valid, .fwd_dest, .fwd_data
  );

  writeback_unit writeback_i (
    .clock, .reset,
    .ex_wb (ex_wb),
    .wr_ena, .wr_addr, .wr_data,
    .commit_valid, .commit_pc, .commit_wen, .commit_wdest, .commit_wdata,
    .uart_valid, .uart_char,
    .halted, .halt_code
  );

endmodule

/* verif/tb_checker.sv */
// reference ISA model with commit, serial and halt comparison and the test report
`include "core_defs.svh"

module tb_checker #(
  parameter int PROG_LEN = 201
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  logic [`XLEN-1:0]       fetch_addr,
  input  logic                   commit_valid,
  input  logic [`XLEN-1:0]       commit_pc,
  input  logic                   commit_wen,
  input  logic [`REG_ADDR_W-1:0] commit_wdest,
  input  logic [`XLEN-1:0]       commit_wdata,
  input  logic                   uart_valid,
  input  logic [7:0]             uart_char,
  input  logic                   halted,
  input  logic [7:0]             halt_code,
  input  logic [`ILEN-1:0]       prog [0:PROG_LEN-1],
  output logic                   done,
  output int                     tests_run,
  output int                     tests_failed,
  output int                     error_total
);
  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;

  logic [`XLEN-1:0] model_regs [0:31];
  int               last_write [0:31];
  logic [7:0]       halt_expected;
  bit               halt_committed = 0;
  int               commit_idx = 0;
  int               dep_count = 0;
  int               x0_count = 0;
  int               err_order = 0;
  int               err_alu = 0;
  int               err_dep = 0;
  int               err_x0 = 0;
  int               err_uart = 0;
  int               err_halt = 0;

  function automatic logic [63:0] model_alu(input logic [2:0] f3, input bit sub,
                                            input logic [63:0] a, input logic [63:0] b);
    case (f3)
      FUNCT3_ADD:  return sub ? a - b : a + b;
      FUNCT3_SLT:  return {63'd0, $signed(a) < $signed(b)};
      FUNCT3_SLTU: return {63'd0, a < b};
      FUNCT3_XOR:  return a ^ b;
      FUNCT3_OR:   return a | b;
      default:     return a & b;
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual, inout int errs);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
      errs++;
    end
  endtask

  // steps the model by one instruction and compares the commit
  task automatic process_commit();
    inst_word_u  w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    bit          is_r;
    int          errs;
    errs = 0;
    if (halt_committed || commit_idx >= PROG_LEN) begin
      $display("commit at pc %h arrived after the halt", commit_pc);
      err_halt++;
      return;
    end
    w    = prog[commit_idx];
    a    = model_regs[w.r_view.rs1];
    is_r = w.r_view.opcode == OPC_OP;
    compare_field("commit_pc", `RESET_PC + 4 * commit_idx, commit_pc, err_order);
    if (is_r || w.r_view.opcode == OPC_OP_IMM) begin
      b   = is_r ? model_regs[w.r_view.rs2] : {{52{w.i_view.imm12[11]}}, w.i_view.imm12};
      res = model_alu(w.r_view.funct3, is_r && w.r_view.funct7 == FUNCT7_SUB, a, b);
      compare_field("commit_wen", 1, commit_wen, errs);
      compare_field("commit_wdest", w.r_view.rd, commit_wdest, errs);
      compare_field("commit_wdata", res, commit_wdata, errs);
      compare_field("uart_valid", 0, uart_valid, errs);
      if (w.r_view.rd == 0 || w.r_view.rs1 == 0 || (is_r && w.r_view.rs2 == 0)) begin
        x0_count++;
        err_x0 += errs;
      end else if (commit_idx - last_write[w.r_view.rs1] <= 2 ||
                   (is_r && commit_idx - last_write[w.r_view.rs2] <= 2)) begin
        dep_count++;
        err_dep += errs;
      end else begin
        err_alu += errs;
      end
      if (w.r_view.rd != 0) begin
        model_regs[w.r_view.rd] = res;
        last_write[w.r_view.rd] = commit_idx;
      end
    end else begin
      compare_field("commit_wen", 0, commit_wen, err_order);
      if (w.r_view.opcode == OPC_PUTCH) begin
        compare_field("uart_valid", 1, uart_valid, err_uart);
        compare_field("uart_char", a[7:0], uart_char, err_uart);
      end else begin
        compare_field("uart_valid", 0, uart_valid, err_uart);
      end
      if (w.r_view.opcode == OPC_HALT) begin
        halt_expected  = model_regs[10][7:0];
        halt_committed = 1;
      end
    end
    commit_idx++;
  endtask

  task automatic finish_test(input string name, input int errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    error_total += errs;
    $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "PASS" : "FAIL");
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      if (halted && commit_valid) begin
        $display("commit_valid high at %0t while halted", $time);
        err_halt++;
      end
      if (commit_valid) begin
        process_commit();
      end else if (uart_valid) begin
        $display("uart_valid high at %0t without a commit", $time);
        err_uart++;
      end
    end
  end

  initial begin
    int n;
    int t1_errs;
    int t6_errs;
    done         = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    error_total  = 0;
    t1_errs      = 0;
    t6_errs      = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
      last_write[i] = -100;
    end

    // first request after reset
    n = 0;
    while ((reset !== 1'b0 || fetch_valid !== 1'b1) && n < 200) begin
      @(negedge clock);
      n++;
    end
    if (reset !== 1'b0 || fetch_valid !== 1'b1) begin
      $display("fetch_valid never rose after reset");
      t1_errs++;
    end else begin
      compare_field("fetch_addr", `RESET_PC, fetch_addr, t1_errs);
      compare_field("commit_valid", 0, commit_valid, t1_errs);
      compare_field("uart_valid", 0, uart_valid, t1_errs);
      compare_field("halted", 0, halted, t1_errs);
    end
    finish_test("reset state", t1_errs);

    n = 0;
    while (!halt_committed && n < 15000) begin
      @(negedge clock);
      n++;
    end
    if (!halt_committed) begin
      $display("the halt did not commit within %0d cycles, %0d commits seen", n, commit_idx);
      err_halt++;
    end
    finish_test("commit order and ALU results", err_order + err_alu);
    if (dep_count == 0) begin
      $display("no back-to-back dependent instruction committed");
      err_dep++;
    end
    finish_test("dependent instructions under fetch gaps", err_dep);
    if (x0_count == 0) begin
      $display("no instruction touching x0 committed");
      err_x0++;
    end
    finish_test("x0 writes and reads", err_x0);
    finish_test("serial output", err_uart);

    // halted is registered one cycle after the halt commits
    n = 0;
    while (!halted && n < 5) begin
      @(negedge clock);
      n++;
    end
    if (!halted) begin
      $display("halted did not rise after the halt commit");
      t6_errs++;
    end else begin
      compare_field("halt_code", halt_expected, halt_code, t6_errs);
      repeat (50) begin
        @(negedge clock);
        compare_field("halted", 1, halted, t6_errs);
      end
    end
    finish_test("halt", t6_errs + err_halt);
    done = 1'b1;
  end

endmodule

/* verif/tb_top.sv */
// testbench top with clock, reset, random program, fetch memory responder and DUT instance
`include "core_defs.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;

  localparam int PROG_LEN  = 201;
  localparam int RUN_LIMIT = 20000;

  logic                   clock;
  logic                   reset;
  logic                   fetch_valid;
  logic [`XLEN-1:0]       fetch_addr;
  logic                   fetch_ready;
  logic [`ILEN-1:0]       fetch_data;
  logic                   commit_valid;
  logic [`XLEN-1:0]       commit_pc;
  logic                   commit_wen;
  logic [`REG_ADDR_W-1:0] commit_wdest;
  logic [`XLEN-1:0]       commit_wdata;
  logic                   uart_valid;
  logic [7:0]             uart_char;
  logic                   halted;
  logic [7:0]             halt_code;

  logic [`ILEN-1:0] prog [0:PROG_LEN-1];
  logic [31:0]      rng_state = 32'h6e42;
  logic             done;
  int               tests_run;
  int               tests_failed;
  int               error_total;
  int               cycles;

  core_top dut_i (.*);

  tb_checker #(.PROG_LEN(PROG_LEN)) checker_i (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // six supported funct3 codes, add weighted a little higher
  function automatic logic [2:0] pick_funct3(input logic [2:0] sel);
    case (sel)
      3'd1:    return FUNCT3_SLT;
      3'd2:    return FUNCT3_SLTU;
      3'd3:    return FUNCT3_XOR;
      3'd4:    return FUNCT3_OR;
      3'd5:    return FUNCT3_AND;
      default: return FUNCT3_ADD;
    endcase
  endfunction

  // registers x0..x15 so that dependencies are frequent
  task automatic build_program();
    logic [31:0]            r;
    logic [31:0]            s;
    logic [2:0]             f3;
    logic [6:0]             f7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r   = next_random();
      s   = next_random();
      rd  = {1'b0, r[3:0]};
      rs1 = {1'b0, r[7:4]};
      rs2 = {1'b0, r[11:8]};
      f3  = pick_funct3(r[14:12]);
      f7  = (f3 == FUNCT3_ADD && r[20]) ? FUNCT7_SUB : 7'd0;
      if (r[18:16] == 3'd0) begin
        prog[i] = {12'd0, rs1, 3'd0, 5'd0, OPC_PUTCH};
      end else if (r[19]) begin
        prog[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
      end else begin
        prog[i] = {s[11:0], rs1, f3, rd, OPC_OP_IMM};
      end
    end
    prog[PROG_LEN-1] = {12'd0, 5'd10, 3'd0, 5'd0, OPC_HALT};
  endtask

  // memory side of the fetch handshake, random ready gaps
  always @(posedge clock) begin
    logic [31:0] r;
    logic [63:0] index;
    #1;
    r     = next_random();
    index = (fetch_addr - `RESET_PC) >> 2;
    fetch_ready = !reset && (r[1:0] != 2'b00);
    fetch_data  = (index < PROG_LEN) ? prog[index] : '0;
  end

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    fetch_ready = 1'b0;
    fetch_data  = '0;
    build_program();
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;
    cycles = 0;
    while (!done && cycles < RUN_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (!done) begin
      $display("run stopped, checker did not finish within %0d cycles", RUN_LIMIT);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total);
    if (!done || tests_failed != 0 || error_total != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  end

endmodule

/* core_top.f */
+incdir+hw
hw/isa_pkg.sv
hw/alu_pkg.sv
hw/core_ifs.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/core_top.sv
verif/tb_checker.sv
verif/tb_top.sv
